/* noc_pkg.sv */
package noc_pkg;

   //////////////////////////////////////////////////
   // mesh geometry
   //////////////////////////////////////////////////

   // 4 by 4 mesh, 2 bits per coordinate
   localparam int mesh_x_size = 4;
   localparam int mesh_y_size = 4;
   localparam int coord_w     = 2;

   //////////////////////////////////////////////////
   // router sizing
   //////////////////////////////////////////////////

   // input buffer depth, must stay a power of two
   localparam int fifo_depth = 4;
   localparam int fifo_ptr_w = $clog2(fifo_depth);
   // count must also hold the full value
   localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

   // local plus four compass ports
   localparam int num_ports = 5;
   localparam int port_w    = 3;

   // port index, used on every per-port array
   typedef enum logic [port_w-1:0] {
      port_local = 3'd0,
      port_east  = 3'd1,
      port_west  = 3'd2,
      port_north = 3'd3,
      port_south = 3'd4
   } port_e;

   //////////////////////////////////////////////////
   // flit and vector types
   //////////////////////////////////////////////////

   // y above x, x in the low bits
   typedef struct packed {
      logic [coord_w-1:0] y;
      logic [coord_w-1:0] x;
   } coord_t;

   // single-flit packet, destination in the upper nibble
   typedef struct packed {
      coord_t     dest;
      logic [3:0] payload;
   } flit_t;

   // one bit per port_e, requests and grants
   typedef logic [num_ports-1:0] port_vec_t;

   // coordinates of this node after reset
   localparam coord_t reset_coord = '{y: 2'd1, x: 2'd1};

endpackage

/* router_cfg.sv */
module router_cfg (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           cfg_we,
   input  noc_pkg::coord_t cfg_coord,
   output noc_pkg::coord_t node_coord
);

   // node position in the mesh
   noc_pkg::coord_t coord_q;

   // load on strobe, takes effect at the next edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         coord_q <= noc_pkg::reset_coord;
      end else if (cfg_we) begin
         coord_q <= cfg_coord;
      end
   end

   // fanned out to every input port's route decision
   assign node_coord = coord_q;

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // a written coordinate names a node inside the mesh
   a_cfg_write: assert property (
      @(posedge clk) disable iff (!arst_n)
      cfg_we |-> (int'(cfg_coord.x) < noc_pkg::mesh_x_size)
             && (int'(cfg_coord.y) < noc_pkg::mesh_y_size)
   ) else $error("router_cfg: bad coordinate write %h", cfg_coord);

endmodule

/* route_compute.sv */
module route_compute (
   input  noc_pkg::coord_t    node_coord,
   input  noc_pkg::coord_t    dest,
   input  logic              req_valid,
   output noc_pkg::port_vec_t req
);

   // dimension-ordered routing, x resolved before y
   always_comb begin
      req = '0;
      if (req_valid) begin
         if (dest.x > node_coord.x) begin
            // column to the right
            req[noc_pkg::port_east] = 1'b1;
         end else if (dest.x < node_coord.x) begin
            req[noc_pkg::port_west] = 1'b1;
         end else if (dest.y > node_coord.y) begin
            // same column, larger y lies south
            req[noc_pkg::port_south] = 1'b1;
         end else if (dest.y < node_coord.y) begin
            req[noc_pkg::port_north] = 1'b1;
         end else begin
            // arrived, hand to the local core
            req[noc_pkg::port_local] = 1'b1;
         end
      end
   end

   // exactly one output per valid head, silence otherwise
   a_req_onehot: assert final (req_valid ? $onehot(req) : (req == '0))
      else $error("route_compute: req %h for dest %h", req, dest);

endmodule

/* input_port.sv */
module input_port (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              wr_valid,
   input  noc_pkg::flit_t     wr_flit,
   input  noc_pkg::coord_t    node_coord,
   input  logic              grant,
   output logic              full,
   output noc_pkg::port_vec_t req,
   output noc_pkg::flit_t     head_flit
);

   //////////////////////////////////////////////////
   // flit buffer
   //////////////////////////////////////////////////

   noc_pkg::flit_t                   mem [noc_pkg::fifo_depth];
   logic [noc_pkg::fifo_ptr_w-1:0]   wr_ptr_q;
   logic [noc_pkg::fifo_ptr_w-1:0]   rd_ptr_q;
   logic [noc_pkg::fifo_cnt_w-1:0]   cnt_q;
   logic [noc_pkg::fifo_cnt_w-1:0]   cnt_next;
   logic                             full_q;
   logic                             head_valid;
   logic                             push;
   logic                             pop;

   // sender honours full, so every strobe is a push
   assign push       = wr_valid;
   assign head_valid = (cnt_q != '0);
   // head leaves in the cycle its output grants it
   assign pop        = grant & head_valid;

   // occupancy after this edge
   always_comb begin
      cnt_next = cnt_q;
      if (push && !pop) begin
         cnt_next = cnt_q + 1'b1;
      end else if (pop && !push) begin
         cnt_next = cnt_q - 1'b1;
      end
   end

   // pointers wrap on their own, depth is 2**ptr_w
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
         full_q   <= 1'b0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
         cnt_q  <= cnt_next;
         // registered, high while all entries are taken
         full_q <= (cnt_next == noc_pkg::fifo_cnt_w'(noc_pkg::fifo_depth));
      end
   end

   // storage only
   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr_q] <= wr_flit;
   end

   assign full      = full_q;
   assign head_flit = mem[rd_ptr_q];

   //////////////////////////////////////////////////
   // route of the head entry
   //////////////////////////////////////////////////

   route_compute u_route (
      .node_coord (node_coord),
      .dest       (head_flit.dest),
      .req_valid  (head_valid),
      .req        (req)
   );

   // sender must stall on full
   a_no_overflow: assert property (
      @(posedge clk) disable iff (!arst_n) full |-> !wr_valid
   ) else $error("input_port: write while full");

   // arbiter must only grant a live head
   a_no_underflow: assert property (
      @(posedge clk) disable iff (!arst_n) grant |-> head_valid
   ) else $error("input_port: grant while empty");

endmodule

/* output_arbiter.sv */
module output_arbiter (
   input  logic              clk,
   input  logic              arst_n,
   input  noc_pkg::port_vec_t req,
   input  noc_pkg::flit_t     in_flit [noc_pkg::num_ports],
   output noc_pkg::port_vec_t grant,
   output logic              out_valid,
   output noc_pkg::flit_t     out_flit
);

   // input served last, search starts one past it
   logic [noc_pkg::port_w-1:0] last_q;
   logic [noc_pkg::port_w-1:0] sel;
   logic                       any_grant;
   logic                       out_valid_q;
   noc_pkg::flit_t             out_flit_q;

   //////////////////////////////////////////////////
   // round-robin pick
   //////////////////////////////////////////////////

   always_comb begin
      int unsigned idx;
      grant = '0;
      sel   = last_q;
      // walk all inputs once, starting after last_q
      for (int i = 1; i <= noc_pkg::num_ports; i++) begin
         idx = (int'(last_q) + i) % noc_pkg::num_ports;
         if ((grant == '0) && req[idx]) begin
            grant[idx] = 1'b1;
            sel        = noc_pkg::port_w'(idx);
         end
      end
   end

   assign any_grant = |grant;

   // pointer moves only when someone was served
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         // local input gets first turn
         last_q      <= noc_pkg::port_south;
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= any_grant;
         if (any_grant) last_q <= sel;
      end
   end

   //////////////////////////////////////////////////
   // output register
   //////////////////////////////////////////////////

   // winning flit, held until the next grant
   always_ff @(posedge clk) begin
      if (any_grant) out_flit_q <= in_flit[sel];
   end

   // one pulse per grant, neighbour always takes it
   assign out_valid = out_valid_q;
   assign out_flit  = out_flit_q;

   // single winner, and only among the requesters
   a_grant_legal: assert property (
      @(posedge clk) disable iff (!arst_n)
      $onehot0(grant) && ((grant & ~req) == '0)
   ) else $error("output_arbiter: grant %h req %h", grant, req);

endmodule

/* router_top.sv */
module router_top (
   input  logic              clk,
   input  logic              arst_n,
   input  noc_pkg::port_vec_t in_valid,
   input  noc_pkg::flit_t     in_flit [noc_pkg::num_ports],
   output noc_pkg::port_vec_t in_full,
   input  logic              cfg_we,
   input  noc_pkg::coord_t    cfg_coord,
   output noc_pkg::coord_t    node_coord,
   output noc_pkg::port_vec_t out_valid,
   output noc_pkg::flit_t     out_flit [noc_pkg::num_ports]
);

   // indexed by input, one bit per output
   noc_pkg::port_vec_t req_by_in   [noc_pkg::num_ports];
   noc_pkg::port_vec_t grant_by_in [noc_pkg::num_ports];
   // indexed by output, one bit per input
   noc_pkg::port_vec_t req_by_out   [noc_pkg::num_ports];
   noc_pkg::port_vec_t grant_by_out [noc_pkg::num_ports];
   noc_pkg::flit_t     head_flit    [noc_pkg::num_ports];
   noc_pkg::port_vec_t in_grant;

   //////////////////////////////////////////////////
   // node coordinates
   //////////////////////////////////////////////////

   router_cfg u_cfg (
      .clk        (clk),
      .arst_n     (arst_n),
      .cfg_we     (cfg_we),
      .cfg_coord  (cfg_coord),
      .node_coord (node_coord)
   );

   //////////////////////////////////////////////////
   // request and grant crossbar wiring
   //////////////////////////////////////////////////

   for (genvar o = 0; o < noc_pkg::num_ports; o++) begin : g_xpose
      for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : g_bit
         assign req_by_out[o][i]  = req_by_in[i][o];
         assign grant_by_in[i][o] = grant_by_out[o][i];
      end
   end

   // one request per input, so at most one bit set here
   for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : g_grant_or
      assign in_grant[i] = |grant_by_in[i];
   end

   // one buffer per incoming link
   for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : g_in
      input_port u_in (
         .clk        (clk),
         .arst_n     (arst_n),
         .wr_valid   (in_valid[i]),
         .wr_flit    (in_flit[i]),
         .node_coord (node_coord),
         .grant      (in_grant[i]),
         .full       (in_full[i]),
         .req        (req_by_in[i]),
         .head_flit  (head_flit[i])
      );
   end

   // one arbiter per outgoing link, all see every head
   for (genvar o = 0; o < noc_pkg::num_ports; o++) begin : g_out
      output_arbiter u_arb (
         .clk       (clk),
         .arst_n    (arst_n),
         .req       (req_by_out[o]),
         .in_flit   (head_flit),
         .grant     (grant_by_out[o]),
         .out_valid (out_valid[o]),
         .out_flit  (out_flit[o])
      );
   end

endmodule

/* tb_router.sv */
module tb_router;

   timeunit 1ns;
   timeprecision 1ps;

   // run limit, about four times the longest expected run
   localparam int max_cycles = 2000;

   logic               clk;
   logic               arst_n;
   noc_pkg::port_vec_t in_valid;
   noc_pkg::flit_t     in_flit [noc_pkg::num_ports];
   noc_pkg::port_vec_t in_full;
   logic               cfg_we;
   noc_pkg::coord_t    cfg_coord;
   noc_pkg::coord_t    node_coord;
   noc_pkg::port_vec_t out_valid;
   noc_pkg::flit_t     out_flit [noc_pkg::num_ports];

   // expected flits, one queue per input and output pair
   noc_pkg::flit_t     exp_q [noc_pkg::num_ports][noc_pkg::num_ports][$];
   noc_pkg::coord_t    tb_coord;
   noc_pkg::port_vec_t exp_vec;
   noc_pkg::port_vec_t out_ok;
   noc_pkg::flit_t     got_flit [noc_pkg::num_ports];
   noc_pkg::flit_t     exp_flit [noc_pkg::num_ports];
   logic               lat_chk;
   logic               full_seen;
   int                 cycles;

   router_top DUT (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_flit    (in_flit),
      .in_full    (in_full),
      .cfg_we     (cfg_we),
      .cfg_coord  (cfg_coord),
      .node_coord (node_coord),
      .out_valid  (out_valid),
      .out_flit   (out_flit)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////

   // x distance first, then y, zero distance means local
   function automatic int xy_port(input noc_pkg::coord_t node, input noc_pkg::coord_t dest);
      int dx;
      int dy;
      dx = int'(dest.x) - int'(node.x);
      dy = int'(dest.y) - int'(node.y);
      if (dx > 0) return int'(noc_pkg::port_east);
      if (dx < 0) return int'(noc_pkg::port_west);
      if (dy > 0) return int'(noc_pkg::port_south);
      if (dy < 0) return int'(noc_pkg::port_north);
      return int'(noc_pkg::port_local);
   endfunction

   function automatic int pending_count();
      int n;
      n = 0;
      for (int i = 0; i < noc_pkg::num_ports; i++) begin
         for (int o = 0; o < noc_pkg::num_ports; o++) n += exp_q[i][o].size();
      end
      return n;
   endfunction

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   // routed with the coordinates valid at acceptance
   task automatic push_expect(input int src, input noc_pkg::flit_t f);
      exp_q[src][xy_port(tb_coord, f.dest)].push_back(f);
   endtask

   //////////////////////////////////////////////////
   // stimulus tasks
   //////////////////////////////////////////////////

   // one flit alone in the router, then wait for its pulse
   task automatic send_single(input int src, input noc_pkg::flit_t f);
      exp_vec = '0;
      exp_vec[xy_port(tb_coord, f.dest)] = 1'b1;
      push_expect(src, f);
      in_flit[src]  = f;
      in_valid[src] = 1'b1;
      @(posedge clk);
      #1;
      in_valid = '0;
      while (out_valid == '0) begin
         @(posedge clk);
         #1;
      end
      // keep exp_vec steady through the latency check edge
      @(posedge clk);
      #1;
   endtask

   // every input streams count flits to dest, stalling on in_full
   task automatic send_burst(input noc_pkg::coord_t dest, input int count);
      int             sent [noc_pkg::num_ports];
      logic           busy;
      noc_pkg::flit_t f;
      foreach (sent[i]) sent[i] = 0;
      busy = 1'b1;
      while (busy) begin
         busy = 1'b0;
         for (int i = 0; i < noc_pkg::num_ports; i++) begin
            in_valid[i] = 1'b0;
            if (sent[i] < count && !in_full[i]) begin
               // payload names the source, top bit flips per flit
               f.dest    = dest;
               f.payload = {sent[i][0], 3'(i)};
               in_flit[i]  = f;
               in_valid[i] = 1'b1;
               push_expect(i, f);
               sent[i]++;
            end
            if (sent[i] < count) busy = 1'b1;
         end
         @(posedge clk);
         #1;
      end
      in_valid = '0;
   endtask

   task automatic wait_drain();
      while (pending_count() != 0) begin
         @(posedge clk);
         #1;
      end
      repeat (2) @(posedge clk);
      #1;
   endtask

   // only while the router holds no flit
   task automatic write_coord(input logic [1:0] x, input logic [1:0] y);
      cfg_coord.x = x;
      cfg_coord.y = y;
      cfg_we      = 1'b1;
      tb_coord    = cfg_coord;
      @(posedge clk);
      #1;
      cfg_we = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // output monitor and checks
   //////////////////////////////////////////////////

   // match each pulse against the queue fronts of its output
   always @(negedge clk) begin
      logic found;
      if (in_full != '0) full_seen = 1'b1;
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
         out_ok[o] = 1'b1;
         if (out_valid[o]) begin
            found       = 1'b0;
            got_flit[o] = out_flit[o];
            exp_flit[o] = '0;
            for (int i = 0; i < noc_pkg::num_ports; i++) begin
               if (!found && exp_q[i][o].size() > 0) begin
                  exp_flit[o] = exp_q[i][o][0];
                  if (exp_q[i][o][0] == out_flit[o]) begin
                     found = 1'b1;
                     void'(exp_q[i][o].pop_front());
                  end
               end
            end
            out_ok[o] = found;
         end
      end
   end

   for (genvar o = 0; o < noc_pkg::num_ports; o++) begin : g_chk
      a_out_flit: assert property (@(posedge clk) disable iff (!arst_n) out_valid[o] |-> out_ok[o])
         else fail_stop($sformatf("error: out_flit[%0d] = %h, expected %h",
                                  o, got_flit[o], exp_flit[o]));
   end

   // lone flit shows up two edges after acceptance
   a_latency: assert property (
      @(posedge clk) disable iff (!arst_n)
      (lat_chk && (in_valid != '0)) |-> ##2 (out_valid == exp_vec)
   ) else fail_stop($sformatf("error: out_valid = %h, expected %h",
                              $sampled(out_valid), exp_vec));

   a_reset_state: assert property (
      @(posedge clk) $rose(arst_n) |-> (out_valid == '0) && (in_full == '0)
   ) else fail_stop($sformatf("error: out_valid = %h, in_full = %h, expected 00",
                              $sampled(out_valid), $sampled(in_full)));

   // reset value until written, then the written value
   a_node_coord: assert property (
      @(posedge clk) disable iff (!arst_n) !cfg_we |-> (node_coord == tb_coord)
   ) else fail_stop($sformatf("error: node_coord = %h, expected %h",
                              $sampled(node_coord), $sampled(tb_coord)));

   always @(posedge clk) begin
      cycles++;
      if (cycles >= max_cycles) fail_stop("timeout: run did not finish in time");
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      noc_pkg::flit_t  f;
      noc_pkg::coord_t d;
      void'($urandom(49));
      arst_n    = 1'b0;
      in_valid  = '0;
      cfg_we    = 1'b0;
      cfg_coord = '0;
      foreach (in_flit[i]) in_flit[i] = '0;
      tb_coord.x = 2'd1;
      tb_coord.y = 2'd1;
      exp_vec    = '0;
      out_ok     = '1;
      lat_chk    = 1'b1;
      full_seen  = 1'b0;
      cycles     = 0;
      repeat (2) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(posedge clk);
      #1;

      // every input to every mesh node
      for (int src = 0; src < noc_pkg::num_ports; src++) begin
         for (int n = 0; n < 16; n++) begin
            f.dest.x  = 2'(n % 4);
            f.dest.y  = 2'(n / 4);
            f.payload = 4'($urandom);
            send_single(src, f);
         end
      end

      // move the node, then a random batch
      write_coord(2'd2, 2'd3);
      for (int n = 0; n < 20; n++) begin
         f = 8'($urandom);
         send_single($urandom_range(4, 0), f);
      end

      // all inputs fight for local, then for east
      lat_chk = 1'b0;
      send_burst(tb_coord, 8);
      d.x = 2'd3;
      d.y = 2'd0;
      send_burst(d, 8);
      wait_drain();
      a_full_seen: assert (full_seen) else fail_stop("in_full never rose during contention");
      a_full_low: assert (in_full == '0)
         else fail_stop($sformatf("error: in_full = %h, expected 00", in_full));

      if (pending_count() == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         fail_stop("flits were never delivered");
      end
   end

endmodule

/* src.f */
noc_pkg.sv
router_cfg.sv
route_compute.sv
input_port.sv
output_arbiter.sv
router_top.sv
tb_router.sv
